//--- source/scc_bus_pkg.sv
// ----------------------------------------
// host bus view of the sound generator
// address map, register indices and bus types
// shared by the register file, tables and testbench
// ----------------------------------------
`default_nettype none

package scc_bus_pkg;

    // host bus widths
    typedef logic [7:0] bus_addr_t;
    typedef logic [7:0] bus_data_t;
    // sample slot inside one 32-entry wave table
    typedef logic [4:0] wave_index_t;

    // ADDR[7:5] regions
    localparam logic [2:0] REGION_WAVE_A = 3'd0;
    localparam logic [2:0] REGION_WAVE_B = 3'd1;
    localparam logic [2:0] REGION_WAVE_C = 3'd2;
    localparam logic [2:0] REGION_WAVE_D = 3'd3;
    localparam logic [2:0] REGION_CTRL   = 3'd4;
    localparam logic [2:0] REGION_WAVE_E = 3'd5;
    localparam logic [2:0] REGION_MODE   = 3'd6;

    // control register file indices
    // divider of channel n at 2n (low byte) and 2n+1 (high nibble)
    localparam int REG_DIV_L = 0;
    localparam int REG_VOL   = 10;
    localparam int REG_ENA   = 15;

    // mode register bits that matter
    localparam int MODE_BIT_4B = 0;
    localparam int MODE_BIT_8B = 1;

    // DOUT value while nobody reads
    localparam bus_data_t BUS_IDLE_DATA = 8'hFF;

endpackage

`default_nettype wire

//--- source/scc_audio_pkg.sv
// ----------------------------------------
// audio side types of the sound generator
// sample, volume, divider and mix widths
// ----------------------------------------
`default_nettype none

package scc_audio_pkg;

    // five wavetable channels
    localparam int CH_COUNT = 5;

    // signed wave sample, -128..127
    typedef logic signed [7:0] sample_t;

    // 4-bit channel volume, 0..15
    typedef logic [3:0] volume_t;

    // 12-bit period divider
    typedef logic [11:0] divider_t;

    // sample times volume, -1920..1905
    typedef logic signed [11:0] amp_t;

    // final mix, -600..595 with five channels
    typedef logic signed [10:0] sound_t;

    // lifts a signed 8-bit level into 0..255 before summing
    localparam int MIX_OFFSET = 128;

endpackage

`default_nettype wire

//--- source/scc_wave_table.sv
// ----------------------------------------
// one 32 x 8 wave memory
// the host bus and the playback counter share one port
// ----------------------------------------
`default_nettype none

module scc_wave_table (
    input  wire                           CLK,
    input  wire                           RESET_n,
    input  wire scc_bus_pkg::wave_index_t sample_index,
    input  wire scc_bus_pkg::wave_index_t bus_index,
    input  wire                           access,
    input  wire                           write,
    input  wire scc_bus_pkg::bus_data_t   wdata,
    output scc_audio_pkg::sample_t        wave_data
);

    scc_audio_pkg::sample_t   mem [32];
    scc_bus_pkg::wave_index_t addr;

    // bus wins the port for the cycle it is active
    assign addr = access ? bus_index : sample_index;

    always_ff @(posedge CLK) begin
        if (write) begin
            mem[addr] <= scc_audio_pkg::sample_t'(wdata);
        end
    end

    // registered read, feeds both the amp and the bus read mux
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            wave_data <= '0;
        end else begin
            wave_data <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- source/scc_wave_counter.sv
// ----------------------------------------
// per-channel period counter
// steps the sample index once per divider period
// restarts when the channel enable rises
// ----------------------------------------
`default_nettype none

module scc_wave_counter (
    input  wire                          CLK,
    input  wire                          RESET_n,
    input  wire                          CLK_EN,
    input  wire                          mode_4b,
    input  wire                          mode_8b,
    input  wire                          enable,
    input  wire scc_audio_pkg::divider_t divider,
    output scc_bus_pkg::wave_index_t     sample_index
);

    scc_audio_pkg::divider_t div_eff;
    scc_audio_pkg::divider_t count;
    logic                    enable_q;
    logic                    restart;

    // 8-bit mode has priority over 4-bit mode
    always_comb begin
        if (mode_8b) begin
            div_eff = {4'h0, divider[7:0]};
        end else if (mode_4b) begin
            div_eff = {8'h00, divider[11:8]};
        end else begin
            div_eff = divider;
        end
    end

    // enable history only moves on CLK_EN
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            enable_q <= 1'b0;
        end else if (CLK_EN) begin
            enable_q <= enable;
        end
    end

    assign restart = CLK_EN && enable && !enable_q;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            count        <= '0;
            sample_index <= '0;
        end else if (restart) begin
            count        <= '0;
            sample_index <= '0;
        end else if (CLK_EN) begin
            // >= so a shrinking divider cannot strand the count
            if (count >= div_eff) begin
                count        <= '0;
                sample_index <= sample_index + 5'd1;
            end else begin
                count <= count + 12'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/scc_volume_amp.sv
// ----------------------------------------
// signed sample times 4-bit volume
// two register stages, magnitude multiply by shift and add
// ----------------------------------------
`default_nettype none

module scc_volume_amp (
    input  wire                         CLK,
    input  wire                         RESET_n,
    input  wire scc_audio_pkg::sample_t sample,
    input  wire scc_audio_pkg::volume_t volume,
    output scc_audio_pkg::amp_t         amp
);

    logic        sign_q;
    logic [7:0]  mag_q;
    logic [11:0] prod;

    // stage 1, split into sign and magnitude
    // magnitude of -128 still fits 8 unsigned bits
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            sign_q <= 1'b0;
            mag_q  <= '0;
        end else begin
            sign_q <= sample[7];
            mag_q  <= sample[7] ? 8'(-sample) : 8'(sample);
        end
    end

    // one shifted partial product per volume bit
    always_comb begin
        prod = '0;
        for (int b = 0; b < $bits(scc_audio_pkg::volume_t); b++) begin
            if (volume[b]) begin
                prod = prod + (12'(mag_q) << b);
            end
        end
    end

    // stage 2, put the sign back
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            amp <= '0;
        end else if (sign_q) begin
            amp <= scc_audio_pkg::amp_t'(~prod + 12'd1);
        end else begin
            amp <= scc_audio_pkg::amp_t'(prod);
        end
    end

endmodule

`default_nettype wire

//--- source/scc_mixer.sv
// ----------------------------------------
// channel mixer
// gates, offsets and sums the channel amps into Sound
// ----------------------------------------
`default_nettype none

module scc_mixer #(
    parameter int CH_COUNT = 5
) (
    input  wire                      CLK,
    input  wire                      RESET_n,
    input  wire [CH_COUNT-1:0]       channel_enable,
    input  wire scc_audio_pkg::amp_t amp [CH_COUNT],
    output scc_audio_pkg::sound_t    Sound
);

    logic [7:0] level [CH_COUNT];
    int         mix_sum;

    // upper 8 bits of the product, moved to unsigned 0..255
    // a disabled channel sits at the midpoint
    always_comb begin
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            if (channel_enable[ch]) begin
                level[ch] = amp[ch][11:4] + 8'(scc_audio_pkg::MIX_OFFSET);
            end else begin
                level[ch] = 8'(scc_audio_pkg::MIX_OFFSET);
            end
        end
    end

    always_comb begin
        mix_sum = 0;
        for (int ch = 0; ch < CH_COUNT; ch++) begin
            mix_sum = mix_sum + int'(level[ch]);
        end
    end

    // remove the offsets again, all channels idle gives 0
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            Sound <= '0;
        end else begin
            Sound <= scc_audio_pkg::sound_t'(mix_sum - scc_audio_pkg::MIX_OFFSET * CH_COUNT);
        end
    end

    // amp range -1920..1905 keeps every level in 8..247
    // so five channels give -600..595
    a_sound_range : assert property (
        @(posedge CLK) disable iff (!RESET_n)
        (Sound >= -120 * CH_COUNT) && (Sound <= 119 * CH_COUNT)
    );

endmodule

`default_nettype wire

//--- source/scc_bus_regs.sv
// ----------------------------------------
// host bus register file and decode
// holds 16 control registers and the mode register
// drives DOUT/BUSDIR_n and the wave table strobes
// ----------------------------------------
`default_nettype none

module scc_bus_regs (
    input  wire                         CLK,
    input  wire                         RESET_n,
    input  wire scc_bus_pkg::bus_addr_t ADDR,
    input  wire                         CS_n,
    input  wire                         RD_n,
    input  wire                         WR_n,
    input  wire scc_bus_pkg::bus_data_t DIN,
    input  wire scc_audio_pkg::sample_t wave_data [scc_audio_pkg::CH_COUNT],
    output scc_bus_pkg::bus_data_t      DOUT,
    output logic                        BUSDIR_n,
    output logic [4:0]                  wave_access,
    output logic [4:0]                  wave_write,
    output scc_audio_pkg::divider_t     divider [scc_audio_pkg::CH_COUNT],
    output scc_audio_pkg::volume_t      volume [scc_audio_pkg::CH_COUNT],
    output logic [4:0]                  channel_enable,
    output logic                        mode_4b,
    output logic                        mode_8b
);

    // region of each wave table, channel order A..E
    localparam logic [2:0] WAVE_REGION [5] = '{
        scc_bus_pkg::REGION_WAVE_A,
        scc_bus_pkg::REGION_WAVE_B,
        scc_bus_pkg::REGION_WAVE_C,
        scc_bus_pkg::REGION_WAVE_D,
        scc_bus_pkg::REGION_WAVE_E
    };

    logic [2:0]             region;
    scc_bus_pkg::bus_data_t ctrl_regs [16];
    scc_bus_pkg::bus_data_t mode_reg;

    assign region = ADDR[7:5];

    // host writes, any cycle with CS_n and WR_n low
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            for (int i = 0; i < 16; i++) begin
                ctrl_regs[i] <= '0;
            end
            mode_reg <= '0;
        end else if (!CS_n && !WR_n) begin
            if (region == scc_bus_pkg::REGION_CTRL) begin
                ctrl_regs[ADDR[3:0]] <= DIN;
            end else if (region == scc_bus_pkg::REGION_MODE) begin
                mode_reg <= DIN;
            end
        end
    end

    // registered read mux
    // wave tables land a cycle later since their output is registered too
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            DOUT     <= scc_bus_pkg::BUS_IDLE_DATA;
            BUSDIR_n <= 1'b1;
        end else if (CS_n || RD_n) begin
            DOUT     <= scc_bus_pkg::BUS_IDLE_DATA;
            BUSDIR_n <= 1'b1;
        end else begin
            BUSDIR_n <= 1'b0;
            case (region)
                scc_bus_pkg::REGION_WAVE_A: DOUT <= scc_bus_pkg::bus_data_t'(wave_data[0]);
                scc_bus_pkg::REGION_WAVE_B: DOUT <= scc_bus_pkg::bus_data_t'(wave_data[1]);
                scc_bus_pkg::REGION_WAVE_C: DOUT <= scc_bus_pkg::bus_data_t'(wave_data[2]);
                scc_bus_pkg::REGION_WAVE_D: DOUT <= scc_bus_pkg::bus_data_t'(wave_data[3]);
                scc_bus_pkg::REGION_CTRL:   DOUT <= ctrl_regs[ADDR[3:0]];
                scc_bus_pkg::REGION_WAVE_E: DOUT <= scc_bus_pkg::bus_data_t'(wave_data[4]);
                scc_bus_pkg::REGION_MODE:   DOUT <= mode_reg;
                default:                    DOUT <= scc_bus_pkg::BUS_IDLE_DATA;
            endcase
        end
    end

    // per-channel strobes and register fields
    always_comb begin
        for (int ch = 0; ch < scc_audio_pkg::CH_COUNT; ch++) begin
            wave_access[ch] = !CS_n && (!RD_n || !WR_n) && (region == WAVE_REGION[ch]);
            wave_write[ch]  = wave_access[ch] && !WR_n;
            // high nibble register only contributes its low 4 bits
            divider[ch] = {ctrl_regs[scc_bus_pkg::REG_DIV_L + 2 * ch + 1][3:0],
                           ctrl_regs[scc_bus_pkg::REG_DIV_L + 2 * ch]};
            volume[ch]  = ctrl_regs[scc_bus_pkg::REG_VOL + ch][3:0];
        end
    end

    assign channel_enable = ctrl_regs[scc_bus_pkg::REG_ENA][4:0];
    assign mode_4b        = mode_reg[scc_bus_pkg::MODE_BIT_4B];
    assign mode_8b        = mode_reg[scc_bus_pkg::MODE_BIT_8B];

    // a host cycle is a read or a write, never both
    a_rd_wr_exclusive : assert property (
        @(posedge CLK) disable iff (!RESET_n) !CS_n |-> (RD_n || WR_n)
    );

endmodule

`default_nettype wire

//--- source/scc_top.sv
// ----------------------------------------
// top of the five-channel wavetable generator
// host bus in, DOUT/BUSDIR_n and Sound out
// ----------------------------------------
`default_nettype none

module scc_top (
    input  wire                       CLK,
    input  wire                       RESET_n,
    input  wire                       CLK_EN,
    input  wire scc_bus_pkg::bus_addr_t ADDR,
    input  wire                       CS_n,
    input  wire                       RD_n,
    input  wire                       WR_n,
    input  wire scc_bus_pkg::bus_data_t DIN,
    output wire scc_bus_pkg::bus_data_t DOUT,
    output wire                       BUSDIR_n,
    output wire scc_audio_pkg::sound_t  Sound
);

    // bus side strobes, one bit per table
    logic [4:0] wave_access;
    logic [4:0] wave_write;

    // register file outputs
    scc_audio_pkg::divider_t divider [scc_audio_pkg::CH_COUNT];
    scc_audio_pkg::volume_t  volume [scc_audio_pkg::CH_COUNT];
    logic [4:0]              channel_enable;
    logic                    mode_4b;
    logic                    mode_8b;

    // per-channel audio path
    scc_audio_pkg::sample_t   wave_data [scc_audio_pkg::CH_COUNT];
    scc_bus_pkg::wave_index_t sample_index [scc_audio_pkg::CH_COUNT];
    scc_audio_pkg::amp_t      amp [scc_audio_pkg::CH_COUNT];

    scc_bus_regs u_bus_regs (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .ADDR           (ADDR),
        .CS_n           (CS_n),
        .RD_n           (RD_n),
        .WR_n           (WR_n),
        .DIN            (DIN),
        .wave_data      (wave_data),
        .DOUT           (DOUT),
        .BUSDIR_n       (BUSDIR_n),
        .wave_access    (wave_access),
        .wave_write     (wave_write),
        .divider        (divider),
        .volume         (volume),
        .channel_enable (channel_enable),
        .mode_4b        (mode_4b),
        .mode_8b        (mode_8b)
    );

    for (genvar ch = 0; ch < scc_audio_pkg::CH_COUNT; ch++) begin : g_channel
        // table address comes from ADDR[4:0] during a bus access
        scc_wave_table u_table (
            .CLK          (CLK),
            .RESET_n      (RESET_n),
            .sample_index (sample_index[ch]),
            .bus_index    (ADDR[4:0]),
            .access       (wave_access[ch]),
            .write        (wave_write[ch]),
            .wdata        (DIN),
            .wave_data    (wave_data[ch])
        );

        scc_wave_counter u_counter (
            .CLK          (CLK),
            .RESET_n      (RESET_n),
            .CLK_EN       (CLK_EN),
            .mode_4b      (mode_4b),
            .mode_8b      (mode_8b),
            .enable       (channel_enable[ch]),
            .divider      (divider[ch]),
            .sample_index (sample_index[ch])
        );

        scc_volume_amp u_amp (
            .CLK     (CLK),
            .RESET_n (RESET_n),
            .sample  (wave_data[ch]),
            .volume  (volume[ch]),
            .amp     (amp[ch])
        );
    end

    scc_mixer #(
        .CH_COUNT (scc_audio_pkg::CH_COUNT)
    ) u_mixer (
        .CLK            (CLK),
        .RESET_n        (RESET_n),
        .channel_enable (channel_enable),
        .amp            (amp),
        .Sound          (Sound)
    );

endmodule

`default_nettype wire

//--- dv/tb_scc.sv
// ----------------------------------------
// testbench for the wavetable generator
// replays dv/scc_vectors.txt against the DUT
// run from the project root through the Makefile
// ----------------------------------------
`default_nettype none

module tb_scc;

    localparam int RESET_CYCLES    = 10;
    localparam int READ_HOLD       = 3;
    localparam int SETTLE_CYCLES   = 200;
    localparam int CYCLES_PER_LINE = 300;

    logic                   CLK;
    logic                   RESET_n;
    logic                   CLK_EN;
    scc_bus_pkg::bus_addr_t ADDR;
    logic                   CS_n;
    logic                   RD_n;
    logic                   WR_n;
    scc_bus_pkg::bus_data_t DIN;
    wire scc_bus_pkg::bus_data_t DOUT;
    wire                         BUSDIR_n;
    wire scc_audio_pkg::sound_t  Sound;

    // one entry per vector line
    byte                    op_q [$];
    scc_bus_pkg::bus_addr_t addr_q [$];
    logic [15:0]            val_q [$];

    int cycle_count;
    int cycle_limit;
    int test_count;
    int fail_count;
    // errors seen inside the running test
    int test_errors;

    scc_top dut (
        .CLK      (CLK),
        .RESET_n  (RESET_n),
        .CLK_EN   (CLK_EN),
        .ADDR     (ADDR),
        .CS_n     (CS_n),
        .RD_n     (RD_n),
        .WR_n     (WR_n),
        .DIN      (DIN),
        .DOUT     (DOUT),
        .BUSDIR_n (BUSDIR_n),
        .Sound    (Sound)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // CLK_EN high on about half of the cycles
    always @(posedge CLK) begin
        #1;
        CLK_EN = 1'($urandom % 2);
    end

    // run limit grows with the number of vector lines
    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_bus(input scc_bus_pkg::bus_data_t exp, input logic exp_dir);
        if (DOUT !== exp) begin
            $display("Fail DOUT: expected %h, got %h", exp, DOUT);
            test_errors++;
        end
        if (BUSDIR_n !== exp_dir) begin
            $display("Fail BUSDIR_n: expected %h, got %h", exp_dir, BUSDIR_n);
            test_errors++;
        end
    endtask

    task automatic check_sound(input scc_audio_pkg::sound_t exp);
        if (Sound !== exp) begin
            $display("Fail Sound: expected %h, got %h", exp, Sound);
            test_errors++;
        end
    endtask

    // one write strobe, then an idle cycle
    task automatic bus_write(input scc_bus_pkg::bus_addr_t a, input scc_bus_pkg::bus_data_t d);
        ADDR = a;
        DIN  = d;
        CS_n = 1'b0;
        WR_n = 1'b0;
        @(posedge CLK);
        #1;
        CS_n = 1'b1;
        WR_n = 1'b1;
        @(posedge CLK);
        #1;
    endtask

    // hold the strobe long enough for the slower wave table path
    task automatic bus_read_check(input scc_bus_pkg::bus_addr_t a,
                                  input scc_bus_pkg::bus_data_t exp);
        ADDR = a;
        CS_n = 1'b0;
        RD_n = 1'b0;
        repeat (READ_HOLD) @(posedge CLK);
        #1;
        check_bus(exp, 1'b0);
        CS_n = 1'b1;
        RD_n = 1'b1;
        @(posedge CLK);
        #1;
    endtask

    task automatic fill_table(input scc_bus_pkg::bus_addr_t base, input scc_bus_pkg::bus_data_t d);
        for (int i = 0; i < 32; i++) begin
            bus_write(base + scc_bus_pkg::bus_addr_t'(i), d);
        end
    endtask

    task automatic settle_check(input scc_audio_pkg::sound_t exp);
        repeat (SETTLE_CYCLES) @(posedge CLK);
        #1;
        check_sound(exp);
    endtask

    task automatic finish_test(input string desc);
        test_count++;
        if (test_errors == 0) begin
            $display("test %0d (%s) ok", test_count, desc);
        end else begin
            fail_count++;
            $display("test %0d (%s) failed, %0d errors", test_count, desc, test_errors);
        end
        test_errors = 0;
    endtask

    // comment lines and blank lines fail the scan and are skipped
    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        byte         op;
        logic [15:0] a;
        logic [15:0] v;
        fd = $fopen("dv/scc_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file dv/scc_vectors.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h", op, a, v);
                if (n == 3 && op != "#") begin
                    op_q.push_back(op);
                    addr_q.push_back(a[7:0]);
                    val_q.push_back(v);
                end
            end
            $fclose(fd);
            if (op_q.size() == 0) begin
                $display("the vector file holds no operations");
                fail_count++;
            end
        end
    endtask

    task automatic run_vector(input int i);
        string desc;
        desc = $sformatf("%c %h %h", op_q[i], addr_q[i], val_q[i]);
        case (op_q[i])
            "W": bus_write(addr_q[i], val_q[i][7:0]);
            "R": bus_read_check(addr_q[i], val_q[i][7:0]);
            "F": fill_table(addr_q[i], val_q[i][7:0]);
            "S": settle_check(scc_audio_pkg::sound_t'(val_q[i][10:0]));
            default: begin
                $display("vector %0d has an unknown op letter", i);
                test_errors++;
            end
        endcase
        finish_test(desc);
    endtask

    initial begin
        void'($urandom(32'h92f8_8a04));
        RESET_n     = 1'b0;
        CLK_EN      = 1'b0;
        ADDR        = '0;
        CS_n        = 1'b1;
        RD_n        = 1'b1;
        WR_n        = 1'b1;
        DIN         = '0;
        cycle_count = 0;
        cycle_limit = 0;
        test_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        load_vectors();
        cycle_limit = CYCLES_PER_LINE * op_q.size() + 100;

        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        RESET_n = 1'b1;

        // idle bus and silent mix right after reset
        @(posedge CLK);
        #1;
        check_bus(scc_bus_pkg::BUS_IDLE_DATA, 1'b1);
        check_sound('0);
        finish_test("reset idle");

        for (int i = 0; i < op_q.size(); i++) begin
            run_vector(i);
        end

        $display("%0d tests run, %0d failed", test_count, fail_count);
        if (fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/scc_bus_pkg.sv
source/scc_audio_pkg.sv
source/scc_wave_table.sv
source/scc_wave_counter.sv
source/scc_volume_amp.sv
source/scc_mixer.sv
source/scc_bus_regs.sv
source/scc_top.sv
dv/tb_scc.sv

//--- Makefile
# Verilator build for the wavetable generator testbench
# override any variable on the command line, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_scc
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

FAIL_MSG  := ** FAIL **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAIL_MSG)' $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/scc_vectors.txt
# op addr data, all hex: W write, R read and compare DOUT, F fill all 32 entries of a table
# S waits 200 cycles then compares Sound; addr unused, data is 11-bit two's complement
W 80 34
W 81 a2
W 8a 0f
W c0 c3
R 80 34
R 81 a2
R 8a 0f
R c0 c3
W 00 11
W 20 22
W 40 33
W 60 44
W a0 55
W 1f 7e
R 00 11
R 20 22
R 40 33
R 60 44
R a0 55
R 1f 7e
F 00 40
F 20 c0
F 40 80
F 60 7f
F a0 10
W 8b 0f
W 8c 0f
W 8d 0f
W 8e 0f
W 8f 00
S 00 000
W 8f 1f
S 00 00e
W c0 01
W 82 ff
W 83 0f
W 8a 08
W 8c 03
W 8f 0d
S 00 07f
W c0 02
W 8f 12
W 8e 07
S 00 7cb
F 20 ff
W 8b 01
S 00 006
